/* verification/tl_bridge_stim.txt */
// read size address wdata wstrb | faults fault_bits final_op final_data | exp_a_data
// exp_rdata exp_denied exp_corrupt exp_a_transfers  (fault k: bit 2k+1 denied, 2k corrupt)
15  // transaction count
0 0 00001000 000000A5 1 0 00 0 00000000 000000A5 00000000 0 0 1
0 0 00001002 123456C3 4 0 00 0 00000000 000000C3 00000000 0 0 1
0 1 00002000 0000BEEF 3 0 00 0 00000000 0000EFBE 00000000 0 0 1
0 1 00002002 ABCD1234 C 0 00 0 00000000 00003412 00000000 0 0 1
0 2 00003000 11223344 F 0 00 0 00000000 44332211 00000000 0 0 1
0 0 00003010 000000FF 3 0 00 0 00000000 00000000 00000000 1 0 0
0 1 00003014 0000FFFF 6 0 00 0 00000000 00000000 00000000 1 0 0
0 2 00003018 FFFFFFFF 7 0 00 0 00000000 00000000 00000000 1 0 0
0 3 00003020 FFFFFFFF F 0 00 0 00000000 00000000 00000000 1 0 0
0 0 00003024 00000011 0 0 00 0 00000000 00000000 00000000 1 0 0
1 0 00004001 00000000 1 0 00 2 DEADBEEF 00000000 000000EF 0 0 1
1 1 00004002 00000000 3 0 00 2 CAFE1234 00000000 00003412 0 0 1
1 2 00004004 00000000 F 0 00 2 DEADBEEF 00000000 EFBEADDE 0 0 1
1 2 00004008 00000000 F 0 00 5 12345678 00000000 00000000 0 1 1
1 2 0000400C 00000000 F 0 00 7 12345678 00000000 00000000 1 0 1
1 2 00004010 00000000 F 0 00 0 12345678 00000000 00000000 0 1 1
1 2 00004014 00000000 F 2 06 2 01020304 00000000 04030201 0 0 3
0 2 00005000 A1B2C3D4 F 3 39 0 00000000 D4C3B2A1 00000000 0 0 4
1 2 00005004 00000000 F 4 9D 2 55555555 00000000 00000000 1 0 4
0 1 00005008 00005AA5 C 4 6A 0 00000000 0000A55A 00000000 0 1 4
0 0 0000500C 0000007E 8 1 03 0 00000000 0000007E 00000000 0 0 2

/* project.f */
+incdir+logic
logic/tl_bridge_pkg.sv
logic/tl_bridge_ctrl.sv
logic/request_capture.sv
logic/response_decode.sv
logic/tl_bridge_top.sv
verification/tb_clock.sv
verification/tb_tl_bridge.sv

/* run.sh */
#!/usr/bin/env bash
# Build the bridge testbench with Verilator and run it from the project root.
# A failing simulation gives a nonzero exit status.
cd "$(dirname "$0")" \
    && verilator --binary --assert --timescale 1ns/1ps \
        --top-module tb_tl_bridge -f project.f -o tb_tl_bridge_sim \
    && ./obj_dir/tb_tl_bridge_sim \
    || exit 1

/* verification/tb_tl_bridge.sv */
////////////////////////////////////////////////////////////
// Bridge testbench
// Plays the CPU and a TileLink-UL slave from a stim file
////////////////////////////////////////////////////////////
`include "tl_bridge_macros.svh"

module tb_tl_bridge;
    timeunit 1ns;
    timeprecision 1ps;

    localparam string       STIM_FILE   = "verification/tl_bridge_stim.txt";
    localparam int          FIELDS      = 14;   // Words per transaction
    localparam int          MAX_TXN     = 32;
    localparam int          TXN_TIMEOUT = 200;  // Cycles per transaction
    localparam int          RST_TIMEOUT = 10;
    localparam logic [31:0] RNG_SEED    = 32'h13fa7159;

    logic                  clk;
    logic                  reset;
    logic                  cpu_ready;
    logic [`TL_XLEN-1:0]   cpu_address;
    logic [`TL_XLEN-1:0]   cpu_wdata;
    logic [`TL_STRB_W-1:0] cpu_wstrb;
    logic [2:0]            cpu_size;
    logic                  cpu_read;
    logic                  cpu_ack;
    logic [`TL_XLEN-1:0]   cpu_rdata;
    logic                  cpu_denied;
    logic                  cpu_corrupt;
    logic                  cpu_valid;
    logic                  tl_a_valid;
    logic                  tl_a_ready;
    logic [2:0]            tl_a_opcode;
    logic [2:0]            tl_a_size;
    logic [`TL_XLEN-1:0]   tl_a_address;
    logic [`TL_STRB_W-1:0] tl_a_mask;
    logic [`TL_XLEN-1:0]   tl_a_data;
    logic                  tl_d_valid;
    logic                  tl_d_ready;
    logic [2:0]            tl_d_opcode;
    logic [`TL_XLEN-1:0]   tl_d_data;
    logic                  tl_d_denied;
    logic                  tl_d_corrupt;

    logic [31:0] stim_mem [0:FIELDS*MAX_TXN];  // Word 0 holds the count
    logic [31:0] rng;
    int          txn_total;
    int          txn_run;

    tb_clock tb_clock_i (
        .clk   (clk),
        .reset (reset)
    );

    tl_bridge_top tl_bridge_top_i (
        .clk          (clk),
        .reset        (reset),
        .cpu_ready    (cpu_ready),
        .cpu_address  (cpu_address),
        .cpu_wdata    (cpu_wdata),
        .cpu_wstrb    (cpu_wstrb),
        .cpu_size     (cpu_size),
        .cpu_read     (cpu_read),
        .cpu_ack      (cpu_ack),
        .cpu_rdata    (cpu_rdata),
        .cpu_denied   (cpu_denied),
        .cpu_corrupt  (cpu_corrupt),
        .cpu_valid    (cpu_valid),
        .tl_a_valid   (tl_a_valid),
        .tl_a_ready   (tl_a_ready),
        .tl_a_opcode  (tl_a_opcode),
        .tl_a_size    (tl_a_size),
        .tl_a_address (tl_a_address),
        .tl_a_mask    (tl_a_mask),
        .tl_a_data    (tl_a_data),
        .tl_d_valid   (tl_d_valid),
        .tl_d_ready   (tl_d_ready),
        .tl_d_opcode  (tl_d_opcode),
        .tl_d_data    (tl_d_data),
        .tl_d_denied  (tl_d_denied),
        .tl_d_corrupt (tl_d_corrupt)
    );

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic check_equal(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("[ERROR] %s: got 0x%08h, expected 0x%08h (transaction %0d)",
                     name, got, expected, txn_run);
            $display("Test failures found");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // One CPU request with its slave script
    ////////////////////////////////////////////////////////////
    task automatic run_transaction(input int base);
        logic        rd;
        logic [2:0]  size;
        logic [31:0] addr;
        logic [3:0]  strb;
        int          nfault;
        logic [31:0] fbits;        // Fault k: bit 2k+1 denied, bit 2k corrupt
        logic [2:0]  final_op;
        logic [31:0] final_data;
        logic [31:0] exp_adata;
        logic [31:0] exp_rdata;
        logic        exp_denied;
        logic        exp_corrupt;
        int          exp_a_count;
        int          a_count;
        int          ack_count;
        int          resp_idx;
        int          cycles;
        logic        a_seen;
        logic        a_fire_prev;  // Transfer due on the coming edge
        logic        d_fire_prev;
        logic        d_pending;
        logic [1:0]  d_wait;
        logic        done;

        rd          = stim_mem[base][0];
        size        = stim_mem[base+1][2:0];
        addr        = stim_mem[base+2];
        strb        = stim_mem[base+4][3:0];
        nfault      = int'(stim_mem[base+5]);
        fbits       = stim_mem[base+6];
        final_op    = stim_mem[base+7][2:0];
        final_data  = stim_mem[base+8];
        exp_adata   = stim_mem[base+9];
        exp_rdata   = stim_mem[base+10];
        exp_denied  = stim_mem[base+11][0];
        exp_corrupt = stim_mem[base+12][0];
        exp_a_count = int'(stim_mem[base+13]);

        // CPU side, held until the ack
        cpu_read    = rd;
        cpu_size    = size;
        cpu_address = addr;
        cpu_wdata   = stim_mem[base+3];
        cpu_wstrb   = strb;
        cpu_ready   = 1'b1;

        a_count     = 0;
        ack_count   = 0;
        resp_idx    = 0;
        cycles      = 0;
        a_seen      = 1'b0;
        a_fire_prev = 1'b0;
        d_fire_prev = 1'b0;
        d_pending   = 1'b0;
        d_wait      = 2'd0;
        done        = 1'b0;

        while (!done) begin
            @(posedge clk);
            #1;                     // Outputs settled, inputs driven here
            cycles++;
            if (cycles > TXN_TIMEOUT) begin
                $display("Transaction %0d got no cpu_valid within %0d cycles",
                         txn_run, TXN_TIMEOUT);
                $display("Test failures found");
                $fatal(1, "Timeout waiting for cpu_valid");
            end
            if (a_fire_prev) begin
                a_count++;
                d_pending = 1'b1;
                d_wait    = rng[5:4];  // Random D latency
            end
            if (d_fire_prev) begin
                tl_d_valid = 1'b0;
                resp_idx++;
            end
            if (cpu_ack) begin
                ack_count++;
                cpu_ready = 1'b0;
            end
            if (cpu_valid) begin
                done = 1'b1;
            end else begin
                // A fields must match the request every offered cycle
                if (tl_a_valid) begin
                    a_seen = 1'b1;
                    check_equal("tl_a_opcode", 32'(tl_a_opcode),
                                32'(rd ? `TL_A_GET : `TL_A_PUT_FULL));
                    check_equal("tl_a_size", 32'(tl_a_size), 32'(size));
                    check_equal("tl_a_address", tl_a_address, addr);
                    check_equal("tl_a_mask", 32'(tl_a_mask), 32'(strb));
                    check_equal("tl_a_data", tl_a_data, exp_adata);
                end
                // D ready from the A transfer until the D transfer
                check_equal("tl_d_ready", 32'(tl_d_ready), 32'(d_pending || tl_d_valid));
                rng        = xorshift32(rng);
                tl_a_ready = (rng[1:0] != 2'b00);  // Back-pressure about 1 in 4
                if (d_pending) begin
                    if (d_wait == 2'd0) begin
                        if (resp_idx < nfault) begin
                            tl_d_opcode  = rd ? `TL_D_ACK_DATA : `TL_D_ACK;
                            tl_d_data    = 32'hbad0_0000 | 32'(resp_idx);
                            tl_d_denied  = fbits[2*resp_idx+1];
                            tl_d_corrupt = fbits[2*resp_idx];
                        end else begin
                            tl_d_opcode  = final_op;
                            tl_d_data    = final_data;
                            tl_d_denied  = 1'b0;
                            tl_d_corrupt = 1'b0;
                        end
                        tl_d_valid = 1'b1;
                        d_pending  = 1'b0;
                    end else begin
                        d_wait = d_wait - 2'd1;
                    end
                end
                a_fire_prev = tl_a_valid && tl_a_ready;
                d_fire_prev = tl_d_valid && tl_d_ready;
            end
        end

        // Result with the cpu_valid pulse
        check_equal("cpu_rdata", cpu_rdata, exp_rdata);
        check_equal("cpu_denied", 32'(cpu_denied), 32'(exp_denied));
        check_equal("cpu_corrupt", 32'(cpu_corrupt), 32'(exp_corrupt));
        check_equal("A transfers", 32'(a_count), 32'(exp_a_count));
        check_equal("tl_a_valid seen", 32'(a_seen), 32'(exp_a_count != 0));
        check_equal("cpu_ack pulses", 32'(ack_count), 32'd1);
        txn_run++;
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////
    initial begin
        int wait_cycles;
        cpu_ready    = 1'b0;
        cpu_address  = '0;
        cpu_wdata    = '0;
        cpu_wstrb    = '0;
        cpu_size     = 3'd0;
        cpu_read     = 1'b0;
        tl_a_ready   = 1'b0;
        tl_d_valid   = 1'b0;
        tl_d_opcode  = 3'd0;
        tl_d_data    = '0;
        tl_d_denied  = 1'b0;
        tl_d_corrupt = 1'b0;
        rng          = RNG_SEED;
        txn_run      = 0;
        wait_cycles  = 0;

        $readmemh(STIM_FILE, stim_mem);
        txn_total = int'(stim_mem[0]);
        if (txn_total < 1 || txn_total > MAX_TXN) begin
            $display("Stimulus file gave an unusable transaction count %0d", txn_total);
            $display("Test failures found");
            $fatal(1, "Bad stimulus file");
        end

        while (reset !== 1'b0) begin
            @(posedge clk);
            wait_cycles++;
            if (wait_cycles > RST_TIMEOUT) begin
                $display("Reset never released");
                $display("Test failures found");
                $fatal(1, "Timeout waiting for reset");
            end
        end
        #1;

        for (int t = 0; t < txn_total; t++) begin
            run_transaction(1 + t * FIELDS);
        end

        if (txn_run == txn_total) begin
            $display("All tests passed!");
            $finish;
        end else begin
            $display("Only %0d of %0d transactions completed", txn_run, txn_total);
            $display("Test failures found");
            $fatal(1, "Incomplete run");
        end
    end

endmodule

/* verification/tb_clock.sv */
////////////////////////////////////////////////////////////
// Testbench clock and reset
// 4 ns clock, reset held for two rising edges
////////////////////////////////////////////////////////////
module tb_clock (
    output logic clk,
    output logic reset
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // 4 ns period
    end

    // Released just after the second edge, like any other input
    initial begin
        reset = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
    end

endmodule

/* logic/tl_bridge_top.sv */
////////////////////////////////////////////////////////////
// CPU load/store to TileLink-UL master bridge
// Controller plus request and response datapaths
////////////////////////////////////////////////////////////
`include "tl_bridge_macros.svh"

module tl_bridge_top (
    input  logic                   clk,
    input  logic                   reset,

    // CPU request and result
    input  logic                   cpu_ready,
    input  logic [`TL_XLEN-1:0]    cpu_address,
    input  logic [`TL_XLEN-1:0]    cpu_wdata,
    input  logic [`TL_STRB_W-1:0]  cpu_wstrb,
    input  logic [2:0]             cpu_size,
    input  logic                   cpu_read,
    output logic                   cpu_ack,
    output logic [`TL_XLEN-1:0]    cpu_rdata,
    output logic                   cpu_denied,
    output logic                   cpu_corrupt,
    output logic                   cpu_valid,

    // TileLink A channel
    output logic                   tl_a_valid,
    input  logic                   tl_a_ready,
    output logic [2:0]             tl_a_opcode,
    output logic [2:0]             tl_a_size,
    output logic [`TL_XLEN-1:0]    tl_a_address,
    output logic [`TL_STRB_W-1:0]  tl_a_mask,
    output logic [`TL_XLEN-1:0]    tl_a_data,

    // TileLink D channel
    input  logic                   tl_d_valid,
    output logic                   tl_d_ready,
    input  logic [2:0]             tl_d_opcode,
    input  logic [`TL_XLEN-1:0]    tl_d_data,
    input  logic                   tl_d_denied,
    input  logic                   tl_d_corrupt
);

    logic capture_en;
    logic resp_take;
    logic resp_final;
    logic store_ok;
    logic is_read;
    logic resp_fault;

    tl_bridge_ctrl tl_bridge_ctrl_i (
        .clk        (clk),
        .reset      (reset),
        .cpu_ready  (cpu_ready),
        .store_ok   (store_ok),
        .is_read    (is_read),
        .resp_fault (resp_fault),
        .tl_a_ready (tl_a_ready),
        .tl_d_valid (tl_d_valid),
        .capture_en (capture_en),
        .resp_take  (resp_take),
        .resp_final (resp_final),
        .cpu_ack    (cpu_ack),
        .cpu_valid  (cpu_valid),
        .tl_a_valid (tl_a_valid),
        .tl_d_ready (tl_d_ready)
    );

    request_capture request_capture_i (
        .clk          (clk),
        .reset        (reset),
        .capture_en   (capture_en),
        .cpu_address  (cpu_address),
        .cpu_wdata    (cpu_wdata),
        .cpu_wstrb    (cpu_wstrb),
        .cpu_size     (cpu_size),
        .cpu_read     (cpu_read),
        .store_ok     (store_ok),
        .is_read      (is_read),
        .tl_a_opcode  (tl_a_opcode),
        .tl_a_size    (tl_a_size),
        .tl_a_address (tl_a_address),
        .tl_a_mask    (tl_a_mask),
        .tl_a_data    (tl_a_data)
    );

    // Read swap uses the captured size
    response_decode response_decode_i (
        .clk          (clk),
        .reset        (reset),
        .capture_en   (capture_en),
        .store_ok     (store_ok),
        .resp_take    (resp_take),
        .resp_final   (resp_final),
        .is_read      (is_read),
        .tl_a_size    (tl_a_size),
        .tl_d_opcode  (tl_d_opcode),
        .tl_d_data    (tl_d_data),
        .tl_d_denied  (tl_d_denied),
        .tl_d_corrupt (tl_d_corrupt),
        .resp_fault   (resp_fault),
        .cpu_rdata    (cpu_rdata),
        .cpu_denied   (cpu_denied),
        .cpu_corrupt  (cpu_corrupt)
    );

endmodule

/* logic/response_decode.sv */
////////////////////////////////////////////////////////////
// Response decode
// D channel classification and CPU result registers
////////////////////////////////////////////////////////////
`include "tl_bridge_macros.svh"

module response_decode
    import tl_bridge_pkg::*;
(
    input  logic                clk,
    input  logic                reset,
    input  logic                capture_en,
    input  logic                store_ok,
    input  logic                resp_take,
    input  logic                resp_final,
    input  logic                is_read,
    input  logic [2:0]          tl_a_size,    // Size of the request in flight
    input  logic [2:0]          tl_d_opcode,
    input  logic [`TL_XLEN-1:0] tl_d_data,
    input  logic                tl_d_denied,
    input  logic                tl_d_corrupt,
    output logic                resp_fault,
    output logic [`TL_XLEN-1:0] cpu_rdata,
    output logic                cpu_denied,
    output logic                cpu_corrupt
);

    logic reject_q;  // Store refused at capture

    assign resp_fault = tl_d_denied || tl_d_corrupt;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            reject_q <= 1'b0;
        end else if (capture_en) begin
            reject_q <= !store_ok;
        end
    end

    ////////////////////////////////////////////////////////////
    // CPU result
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cpu_rdata   <= '0;
            cpu_denied  <= 1'b0;
            cpu_corrupt <= 1'b0;
        end else if (capture_en) begin
            cpu_rdata   <= '0;  // Fresh request, old result gone
            cpu_denied  <= 1'b0;
            cpu_corrupt <= 1'b0;
        end else if (resp_final) begin
            cpu_rdata   <= '0;
            cpu_denied  <= 1'b0;
            cpu_corrupt <= 1'b0;
            if (reject_q) begin
                cpu_denied <= 1'b1;  // Mask did not fit size
            end else if (resp_fault) begin
                // Retries used up, report the last beat as is
                cpu_denied  <= tl_d_denied;
                cpu_corrupt <= tl_d_corrupt;
            end else if (is_read) begin
                case (tl_d_opcode)
                    `TL_D_ACK_DATA:         cpu_rdata   <= lane_swap(tl_d_data, tl_a_size);
                    `TL_D_ACK_DATA_CORRUPT: cpu_corrupt <= 1'b1;
                    `TL_D_ACK_ERROR:        cpu_denied  <= 1'b1;
                    default:                cpu_corrupt <= 1'b1;  // Unexpected read reply
                endcase
            end
            // Clean write ends with zero data and no flags
        end
    end

    ////////////////////////////////////////////////////////////
    // Result only from a D beat or a refused store
    ////////////////////////////////////////////////////////////
    final_source: assert property (@(posedge clk) disable iff (reset)
        resp_final |-> resp_take || reject_q);

    // Refused store never offers a D beat
    reject_no_take: assert property (@(posedge clk) disable iff (reset)
        reject_q && !capture_en |-> !resp_take);

endmodule

/* logic/request_capture.sv */
////////////////////////////////////////////////////////////
// Request capture
// Store mask check, request registers, A channel fields
////////////////////////////////////////////////////////////
`include "tl_bridge_macros.svh"

module request_capture
    import tl_bridge_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   capture_en,
    input  logic [`TL_XLEN-1:0]    cpu_address,
    input  logic [`TL_XLEN-1:0]    cpu_wdata,   // Logical byte order
    input  logic [`TL_STRB_W-1:0]  cpu_wstrb,
    input  logic [2:0]             cpu_size,
    input  logic                   cpu_read,
    output logic                   store_ok,
    output logic                   is_read,
    output logic [2:0]             tl_a_opcode,
    output logic [2:0]             tl_a_size,
    output logic [`TL_XLEN-1:0]    tl_a_address,
    output logic [`TL_STRB_W-1:0]  tl_a_mask,
    output logic [`TL_XLEN-1:0]    tl_a_data    // Bus lane order
);

    logic                  size_ok;
    logic [`TL_XLEN-1:0]   req_address;
    logic [`TL_STRB_W-1:0] req_mask;
    logic [2:0]            req_size;
    bus_word_u             req_data;

    ////////////////////////////////////////////////////////////
    // Mask against size, from the live request
    ////////////////////////////////////////////////////////////
    always_comb begin
        case (cpu_size)
            `TL_SIZE_BYTE: size_ok = ($countones(cpu_wstrb) == 1);  // Any one lane
            `TL_SIZE_HALF: size_ok = (cpu_wstrb == 4'b0011) ||
                                     (cpu_wstrb == 4'b1100);
            `TL_SIZE_WORD: size_ok = (cpu_wstrb == {`TL_STRB_W{1'b1}});
            default:       size_ok = 1'b0;  // Doubleword and above refused
        endcase
    end

    assign store_ok = cpu_read || size_ok;  // Reads never checked

    // Read flag steers the FSM and the decoder
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            is_read <= 1'b0;
        end else if (capture_en) begin
            is_read <= cpu_read;
        end
    end

    // Payload held until the next capture
    always_ff @(posedge clk) begin
        if (capture_en) begin
            req_address <= cpu_address;
            req_mask    <= cpu_wstrb;
            req_size    <= cpu_size;
            req_data    <= lane_swap(cpu_wdata, cpu_size);  // To little-endian lanes
        end
    end

    ////////////////////////////////////////////////////////////
    // A channel fields
    ////////////////////////////////////////////////////////////
    assign tl_a_opcode  = is_read ? `TL_A_GET : `TL_A_PUT_FULL;
    assign tl_a_size    = req_size;
    assign tl_a_address = req_address;
    assign tl_a_mask    = req_mask;
    assign tl_a_data    = req_data.word;

endmodule

/* logic/tl_bridge_ctrl.sv */
////////////////////////////////////////////////////////////
// Bridge controller
// Request FSM, retry counter and handshake outputs
////////////////////////////////////////////////////////////
`include "tl_bridge_macros.svh"

module tl_bridge_ctrl
    import tl_bridge_pkg::*;
(
    input  logic clk,
    input  logic reset,
    input  logic cpu_ready,   // CPU request pending
    input  logic store_ok,    // Mask fits size, or a read
    input  logic is_read,
    input  logic resp_fault,  // Denied or corrupt on D
    input  logic tl_a_ready,
    input  logic tl_d_valid,
    output logic capture_en,  // Latch the CPU request this cycle
    output logic resp_take,   // D beat accepted
    output logic resp_final,  // Latch the CPU result
    output logic cpu_ack,
    output logic cpu_valid,
    output logic tl_a_valid,
    output logic tl_d_ready
);

    ctrl_state_e           state;
    ctrl_state_e           next_state;
    logic [`TL_RETRY_W-1:0] retry_cnt;
    logic                  a_fire;
    logic                  d_fire;
    logic                  do_retry;

    ////////////////////////////////////////////////////////////
    // Handshake decode
    ////////////////////////////////////////////////////////////
    assign a_fire     = tl_a_valid && tl_a_ready;
    assign d_fire     = tl_d_valid && tl_d_ready;
    assign capture_en = (state == IDLE) && cpu_ready;
    assign resp_take  = (state == WAIT_RESP) && d_fire;

    // Faulted beat goes out again while retries remain
    assign do_retry = resp_take && resp_fault &&
                      (retry_cnt < `TL_RETRY_W'(`TL_MAX_RETRIES));

    // Rejected stores sit one cycle in RESPOND before their result
    // so that ack and valid never share a cycle
    assign resp_final = (resp_take && !do_retry) ||
                        ((state == RESPOND) && !cpu_valid);

    ////////////////////////////////////////////////////////////
    // Next state
    ////////////////////////////////////////////////////////////
    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (capture_en) begin
                    next_state = store_ok ? SEND : RESPOND;  // Bad mask skips the bus
                end
            end
            SEND: begin
                if (a_fire) next_state = WAIT_RESP;
            end
            WAIT_RESP: begin
                if (resp_take) begin
                    next_state = do_retry ? SEND : RESPOND;
                end
            end
            RESPOND: begin
                if (cpu_valid) next_state = IDLE;  // Pulse done
            end
            default: next_state = IDLE;
        endcase
    end

    // Registered outputs follow the next state
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state      <= IDLE;
            cpu_ack    <= 1'b0;
            cpu_valid  <= 1'b0;
            tl_a_valid <= 1'b0;
            tl_d_ready <= 1'b0;
        end else begin
            state      <= next_state;
            cpu_ack    <= capture_en;
            cpu_valid  <= resp_final;                // Result lands same edge
            tl_a_valid <= (next_state == SEND);
            tl_d_ready <= (next_state == WAIT_RESP);
        end
    end

    // Retries counted per transaction
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            retry_cnt <= '0;
        end else if (do_retry) begin
            retry_cnt <= retry_cnt + 1'b1;
        end else if (resp_final) begin
            retry_cnt <= '0;
        end
    end

    ////////////////////////////////////////////////////////////
    // Protocol checks
    ////////////////////////////////////////////////////////////
    a_valid_held: assert property (@(posedge clk) disable iff (reset)
        tl_a_valid && !tl_a_ready |=> tl_a_valid);

    cpu_valid_pulse: assert property (@(posedge clk) disable iff (reset)
        cpu_valid |=> !cpu_valid);

    // A refused request was always a store
    no_read_reject: assert property (@(posedge clk) disable iff (reset)
        capture_en && !store_ok |=> !is_read);

endmodule

/* logic/tl_bridge_pkg.sv */
////////////////////////////////////////////////////////////
// TileLink-UL bridge types
// Bus word with byte view, controller states, lane swap
////////////////////////////////////////////////////////////
`include "tl_bridge_macros.svh"

package tl_bridge_pkg;

    // One bus word, seen whole or as byte lanes
    typedef union packed {
        logic [`TL_XLEN-1:0]          word;
        logic [`TL_STRB_W-1:0][7:0]   bytes;  // bytes[0] is lane 0
    } bus_word_u;

    typedef enum logic [1:0] {
        IDLE,       // Waiting for a CPU request
        SEND,       // A channel request offered
        WAIT_RESP,  // Waiting for the D channel
        RESPOND     // Result handed to the CPU
    } ctrl_state_e;

    // Reverse the bytes of an access of the given size
    // Logical byte i lands in lane n-1-i, upper lanes are zero
    function automatic bus_word_u lane_swap(input bus_word_u w, input logic [2:0] size);
        bus_word_u r;
        int        n;
        r.word = '0;
        case (size)
            `TL_SIZE_BYTE: n = 1;
            `TL_SIZE_HALF: n = 2;
            `TL_SIZE_WORD: n = 4;
            default:       n = 0;  // Unsupported size gives zero
        endcase
        for (int i = 0; i < `TL_STRB_W; i++) begin
            if (i < n) begin
                r.bytes[n-1-i] = w.bytes[i];
            end
        end
        return r;
    endfunction

endpackage

/* logic/tl_bridge_macros.svh */
////////////////////////////////////////////////////////////
// TileLink-UL bridge constants
// Widths, channel opcodes, size codes and retry limit
////////////////////////////////////////////////////////////
`ifndef TL_BRIDGE_MACROS_SVH
`define TL_BRIDGE_MACROS_SVH

// Datapath geometry
`define TL_XLEN                32     // Data and address width
`define TL_STRB_W              4      // Byte lanes per word

// A channel opcodes
`define TL_A_GET               3'd4
`define TL_A_PUT_FULL          3'd0

// D channel opcodes
`define TL_D_ACK               3'd0   // Write acknowledge, no data
`define TL_D_ACK_DATA          3'd2
`define TL_D_ACK_DATA_CORRUPT  3'd5
`define TL_D_ACK_ERROR         3'd7

// Log2 of bytes per access
`define TL_SIZE_BYTE           3'd0
`define TL_SIZE_HALF           3'd1
`define TL_SIZE_WORD           3'd2

// Retry of denied or corrupt responses
`define TL_MAX_RETRIES         3
`define TL_RETRY_W             2      // Must hold TL_MAX_RETRIES

`endif
